//--- all.f
source/bus_pkg.sv
source/periph_pkg.sv
source/periph_decode.sv
source/mtimer.sv
source/tx_fifo.sv
source/uart_tx_serial.sv
source/periph_top.sv
verif/periph_checker.sv
verif/tb_periph_top.sv

//--- source/bus_pkg.sv
// register bus types shared by the host, the address decoder and the peripherals
package bus_pkg;

	// --------------------------------------------------
	// widths with a meaning of their own
	// --------------------------------------------------

	// byte address on the register bus
	typedef logic [15:0] bus_addr_t;

	// one register word
	typedef logic [31:0] bus_data_t;

	// one character for the uart
	typedef logic [7:0] byte_t;

	// --------------------------------------------------
	// request and response
	// --------------------------------------------------

	// single-cycle request strobe from the host, 50 bits
	typedef struct packed {
		logic      valid;
		logic      write;
		bus_addr_t addr;
		bus_data_t wdata;
	} bus_req_t;

	// response strobe, always one cycle after the request, 34 bits
	// rdata is zero on an error
	typedef struct packed {
		logic      valid;
		logic      err;
		bus_data_t rdata;
	} bus_rsp_t;

endpackage

//--- source/mtimer.sv
// machine timer with microsecond timebase, 64-bit compare interrupt and debug freeze
`timescale 1ns/1ps

module mtimer
	import bus_pkg::*;
	import periph_pkg::*;
#(
	parameter int CLK_MHZ = 5
) (
	input  logic      clk,
	input  logic      rst_n,
	input  bus_req_t  tmr_req,
	output bus_data_t tmr_rdata,
	input  logic      dbg_halt,
	output logic      timer_irq
);

	localparam int PW = (CLK_MHZ > 1) ? $clog2(CLK_MHZ) : 1;

	typedef logic [63:0] mtime_t;

	logic [PW-1:0] presc_q;
	logic          tick;
	logic          en_q;
	mtime_t        mtime_q;
	mtime_t        cmp_q;
	bus_addr_t     offset;
	logic          wr;
	logic          rd;

	assign offset = tmr_req.addr & ~REGION_MASK;
	assign wr     = tmr_req.valid && tmr_req.write;
	assign rd     = tmr_req.valid && !tmr_req.write;

	// --------------------------------------------------
	// microsecond tick
	// --------------------------------------------------
	// free running, reloads on reaching zero
	assign tick = (presc_q == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			presc_q <= PW'(CLK_MHZ - 1);
		end else if (tick) begin
			presc_q <= PW'(CLK_MHZ - 1);
		end else begin
			presc_q <= presc_q - 1'b1;
		end
	end

	// --------------------------------------------------
	// registers
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			en_q    <= 1'b0;
			mtime_q <= '0;
			// all ones keeps the irq low out of reset
			cmp_q   <= '1;
		end else begin
			if (wr && offset == TMR_CTRL) begin
				en_q <= tmr_req.wdata[0];
			end
			// a bus write wins over the increment
			if (wr && offset == TMR_TIME_LO) begin
				mtime_q[31:0] <= tmr_req.wdata;
			end else if (wr && offset == TMR_TIME_HI) begin
				mtime_q[63:32] <= tmr_req.wdata;
			end else if (tick && en_q && !dbg_halt) begin
				mtime_q <= mtime_q + 64'd1;
			end
			if (wr && offset == TMR_CMP_LO) begin
				cmp_q[31:0] <= tmr_req.wdata;
			end
			if (wr && offset == TMR_CMP_HI) begin
				cmp_q[63:32] <= tmr_req.wdata;
			end
		end
	end

	// read data, one cycle latency
	always_ff @(posedge clk) begin
		if (rd) begin
			case (offset)
				TMR_CTRL:    tmr_rdata <= {31'd0, en_q};
				TMR_TIME_LO: tmr_rdata <= mtime_q[31:0];
				TMR_TIME_HI: tmr_rdata <= mtime_q[63:32];
				TMR_CMP_LO:  tmr_rdata <= cmp_q[31:0];
				TMR_CMP_HI:  tmr_rdata <= cmp_q[63:32];
				default:     tmr_rdata <= '0;
			endcase
		end
	end

	assign timer_irq = (mtime_q >= cmp_q);

	// timebase slower than the clock means isolated tick pulses
	tick_isolated: assert property (@(posedge clk) disable iff (!rst_n)
		(CLK_MHZ > 1) && tick |=> !tick);

endmodule

//--- source/periph_decode.sv
// bus decoder: routes host requests to the timer or uart registers and answers one cycle later
`timescale 1ns/1ps

module periph_decode
	import bus_pkg::*;
	import periph_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  bus_req_t  req,
	output bus_rsp_t  rsp,
	output bus_req_t  tmr_req,
	input  bus_data_t tmr_rdata,
	output logic      push,
	output byte_t     push_data,
	input  logic      full,
	input  logic      empty,
	input  logic      busy
);

	bus_addr_t region;
	bus_addr_t offset;
	logic      tmr_hit;
	logic      tx_hit;
	logic      status_hit;
	logic      err_d;
	bus_data_t uart_rdata_d;

	logic      rsp_valid_q;
	logic      rsp_err_q;
	logic      sel_tmr_q;
	bus_data_t uart_rdata_q;

	// --------------------------------------------------
	// address decode
	// --------------------------------------------------
	assign region = req.addr & REGION_MASK;
	assign offset = req.addr & ~REGION_MASK;

	assign tmr_hit = (region == TIMER_BASE) &&
		(offset == TMR_CTRL || offset == TMR_TIME_LO || offset == TMR_TIME_HI ||
		offset == TMR_CMP_LO || offset == TMR_CMP_HI);
	assign tx_hit     = (region == UART_BASE) && (offset == UART_TXDATA);
	assign status_hit = (region == UART_BASE) && (offset == UART_STATUS);

	// timer gets the request only when it lands on one of its registers
	always_comb begin
		tmr_req       = req;
		tmr_req.valid = req.valid && tmr_hit;
	end

	// a byte goes straight into the fifo unless it is full
	assign push      = req.valid && req.write && tx_hit && !full;
	assign push_data = req.wdata[7:0];

	assign err_d = !(tmr_hit || tx_hit || status_hit) || (tx_hit && req.write && full);
	assign uart_rdata_d = (status_hit && !req.write) ? {29'd0, busy, empty, full} : '0;

	// --------------------------------------------------
	// response stage
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsp_valid_q <= 1'b0;
			rsp_err_q   <= 1'b0;
			sel_tmr_q   <= 1'b0;
		end else begin
			rsp_valid_q <= req.valid;
			rsp_err_q   <= req.valid && err_d;
			// timer read data is already registered on its side
			sel_tmr_q   <= req.valid && tmr_hit && !req.write;
		end
	end

	always_ff @(posedge clk) begin
		if (req.valid) begin
			uart_rdata_q <= uart_rdata_d;
		end
	end

	assign rsp.valid = rsp_valid_q;
	assign rsp.err   = rsp_err_q;
	assign rsp.rdata = sel_tmr_q ? tmr_rdata : uart_rdata_q;

	// every response answers a request of the previous cycle
	rsp_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
		rsp.valid |-> $past(req.valid));

endmodule

//--- source/periph_pkg.sv
// address map, register offsets and uart serializer states of the peripheral block
package periph_pkg;

	// --------------------------------------------------
	// regions, picked by the top two address bits
	// --------------------------------------------------
	localparam bus_pkg::bus_addr_t REGION_MASK = 16'hC000;
	localparam bus_pkg::bus_addr_t TIMER_BASE  = 16'h0000;
	localparam bus_pkg::bus_addr_t UART_BASE   = 16'h4000;

	// --------------------------------------------------
	// timer registers
	// --------------------------------------------------
	// bit 0 enables counting
	localparam bus_pkg::bus_addr_t TMR_CTRL    = 16'h0000;
	localparam bus_pkg::bus_addr_t TMR_TIME_LO = 16'h0004;
	localparam bus_pkg::bus_addr_t TMR_TIME_HI = 16'h0008;
	localparam bus_pkg::bus_addr_t TMR_CMP_LO  = 16'h000C;
	localparam bus_pkg::bus_addr_t TMR_CMP_HI  = 16'h0010;

	// --------------------------------------------------
	// uart registers
	// --------------------------------------------------
	// write only
	localparam bus_pkg::bus_addr_t UART_TXDATA = 16'h0000;
	// bit 0 full, bit 1 empty, bit 2 busy
	localparam bus_pkg::bus_addr_t UART_STATUS = 16'h0004;

	// 8N1 frame phases
	typedef enum logic [1:0] {IDLE, START, DATA, STOP} tx_state_t;

endpackage

//--- source/periph_top.sv
// peripheral block top: bus decoder, machine timer and uart transmit path
`timescale 1ns/1ps

module periph_top
	import bus_pkg::*;
#(
	parameter int CLK_MHZ      = 5,
	parameter int CLKS_PER_BIT = 8,
	parameter int FIFO_DEPTH   = 4
) (
	input  logic     clk,
	input  logic     rst_n,
	input  bus_req_t req,
	output bus_rsp_t rsp,
	input  logic     dbg_halt,
	output logic     timer_irq,
	output logic     tx
);

	bus_req_t  tmr_req;
	bus_data_t tmr_rdata;
	logic      push;
	byte_t     push_data;
	logic      pop;
	byte_t     pop_data;
	logic      full;
	logic      empty;
	logic      busy;

	// --------------------------------------------------
	// bus side
	// --------------------------------------------------
	periph_decode decode_u (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.rsp       (rsp),
		.tmr_req   (tmr_req),
		.tmr_rdata (tmr_rdata),
		.push      (push),
		.push_data (push_data),
		.full      (full),
		.empty     (empty),
		.busy      (busy)
	);

	mtimer #(
		.CLK_MHZ (CLK_MHZ)
	) timer_u (
		.clk       (clk),
		.rst_n     (rst_n),
		.tmr_req   (tmr_req),
		.tmr_rdata (tmr_rdata),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq)
	);

	// --------------------------------------------------
	// uart transmit path
	// --------------------------------------------------
	tx_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) fifo_u (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.pop_data  (pop_data),
		.full      (full),
		.empty     (empty)
	);

	uart_tx_serial #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) serial_u (
		.clk      (clk),
		.rst_n    (rst_n),
		.pop_data (pop_data),
		.empty    (empty),
		.pop      (pop),
		.busy     (busy),
		.tx       (tx)
	);

endmodule

//--- source/tx_fifo.sv
// byte FIFO between the bus decoder and the uart serializer
`timescale 1ns/1ps

module tx_fifo
	import bus_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  push,
	input  byte_t push_data,
	input  logic  pop,
	output byte_t pop_data,
	output logic  full,
	output logic  empty
);

	localparam int AW = $clog2(FIFO_DEPTH);

	byte_t         mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;

	// storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign pop_data = mem[rd_ptr];
	assign full     = (count == (AW + 1)'(FIFO_DEPTH));
	assign empty    = (count == '0);

	// --------------------------------------------------
	// producer and consumer must respect the flags
	// --------------------------------------------------
	no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
	no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

//--- source/uart_tx_serial.sv
// 8N1 uart transmitter that drains bytes from the FIFO back to back
`timescale 1ns/1ps

module uart_tx_serial
	import bus_pkg::*;
	import periph_pkg::*;
#(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic  clk,
	input  logic  rst_n,
	input  byte_t pop_data,
	input  logic  empty,
	output logic  pop,
	output logic  busy,
	output logic  tx
);

	localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

	tx_state_t     state_q;
	logic [CW-1:0] clk_cnt_q;
	logic [2:0]    bit_idx_q;
	byte_t         shift_q;
	logic          bit_end;

	assign bit_end = (clk_cnt_q == CW'(CLKS_PER_BIT - 1));

	// take the next byte when idle or right as the stop bit ends
	assign pop  = !empty && (state_q == IDLE || (state_q == STOP && bit_end));
	assign busy = (state_q != IDLE);

	// --------------------------------------------------
	// frame sequencing
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q   <= IDLE;
			clk_cnt_q <= '0;
			bit_idx_q <= '0;
		end else if (pop) begin
			state_q   <= START;
			clk_cnt_q <= '0;
		end else if (state_q != IDLE) begin
			clk_cnt_q <= bit_end ? '0 : clk_cnt_q + 1'b1;
			if (bit_end) begin
				case (state_q)
					START: begin
						state_q   <= DATA;
						bit_idx_q <= '0;
					end
					DATA: begin
						if (bit_idx_q == 3'd7) begin
							state_q <= STOP;
						end
						bit_idx_q <= bit_idx_q + 1'b1;
					end
					default: state_q <= IDLE;
				endcase
			end
		end
	end

	// lsb first
	always_ff @(posedge clk) begin
		if (pop) begin
			shift_q <= pop_data;
		end else if (state_q == DATA && bit_end) begin
			shift_q <= shift_q >> 1;
		end
	end

	assign tx = (state_q == START) ? 1'b0 : (state_q == DATA) ? shift_q[0] : 1'b1;

endmodule

//--- verif/periph_checker.sv
// testbench checker that compares bus responses, the timer irq and uart frames with expected values
`timescale 1ns/1ps

module periph_checker
	import bus_pkg::*;
	import periph_pkg::*;
#(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic      clk,
	input  logic      rst_n,
	input  bus_req_t  req,
	input  bus_rsp_t  rsp,
	input  logic      tx,
	input  logic      timer_irq,
	input  logic      data_chk,
	input  logic      near_chk,
	input  logic      same_chk,
	input  bus_data_t exp_rdata,
	input  logic      exp_err,
	input  logic      irq_chk,
	input  logic      exp_irq,
	output int        bus_errors,
	output int        tx_errors,
	output int        pending_bytes
);

	byte_t     sent_q[$];
	int        bus_cnt = 0;
	int        tx_cnt = 0;
	int        pushed = 0;
	int        seen = 0;
	bus_req_t  pend_req;
	bus_data_t pend_rdata;
	bus_data_t last_rdata;
	logic      pend_data, pend_near, pend_same, pend_err, pend_irq_chk, pend_irq;

	assign bus_errors    = bus_cnt;
	assign tx_errors     = tx_cnt;
	assign pending_bytes = pushed - seen;

	task automatic report_bus(input string msg);
		$display("MISMATCH at %0d ns: %s", $time, msg);
		bus_cnt++;
	endtask

	// --------------------------------------------------
	// bus responses and irq
	// --------------------------------------------------
	// expectations travel with the request and meet the response one cycle later
	always @(posedge clk) begin
		pend_req     <= req;
		pend_rdata   <= exp_rdata;
		pend_err     <= exp_err;
		pend_data    <= data_chk;
		pend_near    <= near_chk;
		pend_same    <= same_chk;
		pend_irq_chk <= irq_chk;
		pend_irq     <= exp_irq;
		// a byte the fifo takes is due on tx later
		if (req.valid && req.write && req.addr == (UART_BASE | UART_TXDATA) && !exp_err) begin
			sent_q.push_back(req.wdata[7:0]);
			pushed <= pushed + 1;
		end
	end

	// registered outputs are settled by the falling edge
	always @(negedge clk) begin
		if (rst_n && rsp.valid !== pend_req.valid) begin
			$display("response strobe at %0d ns does not follow a request by one cycle", $time);
			bus_cnt++;
		end else if (rst_n && pend_req.valid) begin
			if (rsp.err !== pend_err) begin
				report_bus($sformatf("addr 0x%h err %b, expected %b",
					pend_req.addr, rsp.err, pend_err));
			end
			if (pend_data && rsp.rdata !== pend_rdata) begin
				report_bus($sformatf("addr 0x%h rdata 0x%h, expected 0x%h",
					pend_req.addr, rsp.rdata, pend_rdata));
			end
			if (pend_near && ($isunknown(rsp.rdata) || rsp.rdata > pend_rdata + 1 ||
				rsp.rdata + 1 < pend_rdata)) begin
				report_bus($sformatf("addr 0x%h rdata %0d, expected %0d within one",
					pend_req.addr, rsp.rdata, pend_rdata));
			end
			if (pend_same && rsp.rdata !== last_rdata) begin
				report_bus($sformatf("addr 0x%h rdata 0x%h moved from 0x%h during halt",
					pend_req.addr, rsp.rdata, last_rdata));
			end
			if (!pend_req.write) begin
				last_rdata = rsp.rdata;
			end
		end
		if (rst_n && pend_irq_chk && timer_irq !== pend_irq) begin
			report_bus($sformatf("timer_irq %b, expected %b", timer_irq, pend_irq));
		end
	end

	// --------------------------------------------------
	// uart frames sampled at mid-bit
	// --------------------------------------------------
	initial begin : frame_rx
		byte_t got;
		byte_t want;
		forever begin
			@(negedge clk);
			if (rst_n && tx === 1'b0) begin
				// first falling edge inside the start bit
				repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
				if (tx !== 1'b0) begin
					$display("MISMATCH at %0d ns: start bit too short", $time);
					tx_cnt++;
				end
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge clk);
					got[i] = tx;
				end
				repeat (CLKS_PER_BIT) @(negedge clk);
				if (tx !== 1'b1) begin
					$display("MISMATCH at %0d ns: stop bit is %b", $time, tx);
					tx_cnt++;
				end
				if (sent_q.size() == 0) begin
					$display("frame 0x%h on tx at %0d ns without an accepted byte", got, $time);
					tx_cnt++;
				end else begin
					want = sent_q.pop_front();
					seen++;
					if (got !== want) begin
						$display("MISMATCH at %0d ns: tx byte 0x%h, expected 0x%h",
							$time, got, want);
						tx_cnt++;
					end
				end
			end
		end
	end

endmodule

//--- verif/tb_periph_top.sv
// testbench top: clock, reset, stimulus table and watchdog around the peripheral block
`timescale 1ns/1ps

module tb_periph_top
	import bus_pkg::*;
	import periph_pkg::*;
#(
	parameter int CLK_MHZ      = 5,
	parameter int CLKS_PER_BIT = 8,
	parameter int FIFO_DEPTH   = 4
) ();

	localparam int        RESET_CYCLES = 8;
	localparam int        RUN_CYCLES   = 100;
	localparam int        HALT_CYCLES  = 30;
	localparam bus_addr_t TX_ADDR      = UART_BASE | UART_TXDATA;
	localparam bus_addr_t STAT_ADDR    = UART_BASE | UART_STATUS;
	// uart status bits
	localparam bus_data_t ST_FULL      = 32'd1;
	localparam bus_data_t ST_EMPTY     = 32'd2;
	localparam bus_data_t ST_BUSY      = 32'd4;

	typedef enum logic [2:0] {OP_RD, OP_WR, OP_TX, OP_IRQ, OP_DRAIN} op_t;
	// how read data is judged
	typedef enum logic [1:0] {K_EXACT, K_NEAR, K_SAME, K_ANY} kind_t;

	typedef struct packed {
		op_t         op;
		kind_t       kind;
		bus_addr_t   addr;
		bus_data_t   wdata;
		logic        halt;
		bus_data_t   exp_rdata;
		logic        exp_err;
		logic [15:0] wait_cycles;
	} step_t;

	logic      clk, rst_n, dbg_halt, timer_irq, tx;
	bus_req_t  req;
	bus_rsp_t  rsp;
	logic      data_chk, near_chk, same_chk, exp_err, irq_chk, exp_irq;
	bus_data_t exp_rdata;
	int        bus_errors, tx_errors, pending_bytes;
	int        limit_cycles = 0;
	logic [7:0] lfsr_state = 8'd36;
	step_t     stim_q[$];

	always #2 clk = ~clk;

	periph_top #(
		.CLK_MHZ      (CLK_MHZ),
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.FIFO_DEPTH   (FIFO_DEPTH)
	) dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.rsp       (rsp),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq),
		.tx        (tx)
	);

	periph_checker #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) check_u (
		.clk           (clk),
		.rst_n         (rst_n),
		.req           (req),
		.rsp           (rsp),
		.tx            (tx),
		.timer_irq     (timer_irq),
		.data_chk      (data_chk),
		.near_chk      (near_chk),
		.same_chk      (same_chk),
		.exp_rdata     (exp_rdata),
		.exp_err       (exp_err),
		.irq_chk       (irq_chk),
		.exp_irq       (exp_irq),
		.bus_errors    (bus_errors),
		.tx_errors     (tx_errors),
		.pending_bytes (pending_bytes)
	);

	// --------------------------------------------------
	// random bytes and the stimulus table
	// --------------------------------------------------
	// galois form of x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
	endfunction

	task automatic random_byte(output byte_t b);
		for (int i = 0; i < 8; i++) begin
			b[i] = lfsr_state[0];
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic add_step(input op_t op, input kind_t kind, input bus_addr_t addr,
		input bus_data_t wdata, input logic halt, input bus_data_t exp_rd,
		input logic exp_e, input int wait_cycles);
		stim_q.push_back('{op, kind, addr, wdata, halt, exp_rd, exp_e, 16'(wait_cycles)});
	endtask

	task automatic build_table();
		bus_addr_t rb_addr[4];
		bus_data_t rb_data[4];
		rb_addr = '{TMR_TIME_LO, TMR_TIME_HI, TMR_CMP_LO, TMR_CMP_HI};
		rb_data = '{32'h1234_5678, 32'hCAFE_0001, 32'hA5A5_0F0F, 32'h0000_0003};
		// irq low out of reset, then holes in the map
		add_step(OP_IRQ, K_ANY, 0, 0, 0, 0, 0, 0);
		add_step(OP_RD, K_EXACT, 16'h8000, 0, 0, 0, 1, 0);
		add_step(OP_WR, K_EXACT, 16'hC010, 1, 0, 0, 1, 0);
		add_step(OP_RD, K_EXACT, 16'h0014, 0, 0, 0, 1, 0);
		add_step(OP_RD, K_EXACT, 16'h4008, 0, 0, 0, 1, 0);
		add_step(OP_RD, K_EXACT, TMR_CTRL, 0, 0, 0, 0, 0);
		add_step(OP_RD, K_EXACT, STAT_ADDR, 0, 0, ST_EMPTY, 0, 0);
		foreach (rb_addr[i]) begin
			add_step(OP_WR, K_EXACT, rb_addr[i], rb_data[i], 0, 0, 0, 0);
			add_step(OP_RD, K_EXACT, rb_addr[i], 0, 0, rb_data[i], 0, 0);
		end
		// count from zero, then freeze
		add_step(OP_WR, K_EXACT, TMR_TIME_LO, 0, 0, 0, 0, 0);
		add_step(OP_WR, K_EXACT, TMR_TIME_HI, 0, 0, 0, 0, 0);
		add_step(OP_WR, K_EXACT, TMR_CMP_HI, 0, 0, 0, 0, 0);
		add_step(OP_WR, K_EXACT, TMR_CTRL, 1, 0, 0, 0, RUN_CYCLES);
		add_step(OP_RD, K_NEAR, TMR_TIME_LO, 0, 0, RUN_CYCLES / CLK_MHZ, 0, 0);
		add_step(OP_RD, K_ANY, TMR_TIME_LO, 0, 1, 0, 0, HALT_CYCLES);
		add_step(OP_RD, K_SAME, TMR_TIME_LO, 0, 1, 0, 0, 0);
		// compare below, then far above the running time
		add_step(OP_WR, K_EXACT, TMR_CMP_LO, 1, 0, 0, 0, 0);
		add_step(OP_IRQ, K_ANY, 0, 0, 0, 1, 0, 0);
		add_step(OP_WR, K_EXACT, TMR_CMP_LO, 32'h0010_0000, 0, 0, 0, 0);
		add_step(OP_IRQ, K_ANY, 0, 0, 0, 0, 0, 0);
		for (int i = 0; i < 3; i++) begin
			add_step(OP_TX, K_EXACT, TX_ADDR, 0, 0, 0, 0, 0);
		end
		add_step(OP_DRAIN, K_ANY, 0, 0, 0, 0, 0, CLKS_PER_BIT);
		add_step(OP_RD, K_EXACT, STAT_ADDR, 0, 0, ST_EMPTY, 0, 0);
		// idle serializer takes the first byte, so one more fits before a drop
		for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
			add_step(OP_TX, K_EXACT, TX_ADDR, 0, 0, 0, i > FIFO_DEPTH, 0);
		end
		add_step(OP_RD, K_EXACT, STAT_ADDR, 0, 0, ST_FULL | ST_BUSY, 0, 0);
		add_step(OP_DRAIN, K_ANY, 0, 0, 0, 0, 0, CLKS_PER_BIT);
		add_step(OP_RD, K_EXACT, STAT_ADDR, 0, 0, ST_EMPTY, 0, 0);
	endtask

	// --------------------------------------------------
	// driving, on the falling edge
	// --------------------------------------------------
	task automatic clear_drive();
		req       = '0;
		data_chk  = 1'b0;
		near_chk  = 1'b0;
		same_chk  = 1'b0;
		exp_rdata = '0;
		exp_err   = 1'b0;
		irq_chk   = 1'b0;
		exp_irq   = 1'b0;
	endtask

	task automatic apply_step(input step_t s);
		byte_t b;
		dbg_halt = s.halt;
		if (s.op == OP_IRQ) begin
			irq_chk = 1'b1;
			exp_irq = s.exp_rdata[0];
		end else if (s.op == OP_DRAIN) begin
			// every accepted byte seen on tx
			wait (pending_bytes == 0);
		end else begin
			req.valid = 1'b1;
			req.write = (s.op != OP_RD);
			req.addr  = s.addr;
			req.wdata = s.wdata;
			if (s.op == OP_TX) begin
				random_byte(b);
				req.wdata = {24'd0, b};
			end
			data_chk  = (s.kind == K_EXACT);
			near_chk  = (s.kind == K_NEAR);
			same_chk  = (s.kind == K_SAME);
			exp_rdata = s.exp_rdata;
			exp_err   = s.exp_err;
		end
		@(negedge clk);
		clear_drive();
		repeat (s.wait_cycles) @(negedge clk);
	endtask

	initial begin : main
		int cycles;
		clk      = 1'b0;
		rst_n    = 1'b0;
		dbg_halt = 1'b0;
		clear_drive();
		build_table();
		cycles = RESET_CYCLES + 200;
		foreach (stim_q[i]) begin
			cycles += 1 + stim_q[i].wait_cycles;
			if (stim_q[i].op == OP_TX) begin
				cycles += 10 * CLKS_PER_BIT;
			end
		end
		limit_cycles = cycles;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		foreach (stim_q[i]) begin
			apply_step(stim_q[i]);
		end
		repeat (4) @(negedge clk);
		$display("bus errors %0d, tx errors %0d, bytes missing on tx %0d",
			bus_errors, tx_errors, pending_bytes);
		if (bus_errors == 0 && tx_errors == 0 && pending_bytes == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin : watchdog
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: stimulus did not finish within %0d cycles", limit_cycles);
		$display("Errors found");
		$finish;
	end

endmodule
